/* button_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module button_debounce (
  input  logic clk_33m,
  input  logic rst_n,
  // 1 when pressed
  input  logic clock_btn,
  // 0 when pressed
  input  logic duck_btn_n,
  // debounced, active high
  output logic btn_jump,
  output logic btn_duck
);

  // bit positions of the two buttons
  localparam int JUMP_IDX = 0;
  localparam int DUCK_IDX = 1;
  localparam int CNT_W    = $clog2(`RUNNER_DEBOUNCE_CYCLES);

  // both buttons as active high
  logic [1:0]       btn_raw;
  // two flop synchronizer
  logic [1:0]       sync_1;
  logic [1:0]       sync_2;
  // accepted level per button
  logic [1:0]       btn_state;
  // cycles the synchronized level has differed from btn_state
  logic [CNT_W-1:0] stable_cnt [2];

  assign btn_raw[JUMP_IDX] = clock_btn;
  assign btn_raw[DUCK_IDX] = ~duck_btn_n;

  always_ff @(posedge clk_33m or negedge rst_n) begin
    if (!rst_n) begin
      sync_1     <= '0;
      sync_2     <= '0;
      btn_state  <= '0;
      stable_cnt <= '{default: '0};
    end else begin
      sync_1 <= btn_raw;
      sync_2 <= sync_1;
      for (int i = 0; i < 2; i++) begin
        if (sync_2[i] == btn_state[i]) begin
          // bounce back, start over
          stable_cnt[i] <= '0;
        end else if (stable_cnt[i] == CNT_W'(`RUNNER_DEBOUNCE_CYCLES - 1)) begin
          // new level held long enough
          btn_state[i]  <= sync_2[i];
          stable_cnt[i] <= '0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign btn_jump = btn_state[JUMP_IDX];
  assign btn_duck = btn_state[DUCK_IDX];

endmodule

`default_nettype wire

/* motion_detector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module motion_detector (
  input  logic                                clk_33m,
  input  logic                                rst_n,
  // decoded sensor samples
  input  logic signed [`RUNNER_SAMPLE_W-1:0] acceleration,
  input  logic signed [`RUNNER_SAMPLE_W-1:0] direction,
  input  logic                                sample_valid,
  // thresholds from the register block
  input  logic        [`RUNNER_SAMPLE_W-1:0] jump_thresh,
  input  logic        [`RUNNER_SAMPLE_W-1:0] duck_thresh,
  // requests, held between samples
  output logic                                sensor_jump,
  output logic                                sensor_duck
);

  // next level of one request for a sample against its threshold
  function automatic logic next_req(
    input logic                               cur,
    input logic signed [`RUNNER_SAMPLE_W-1:0] sample,
    input logic signed [`RUNNER_SAMPLE_W-1:0] thresh
  );
    logic signed [`RUNNER_SAMPLE_W:0] low_bound;
    // one extra bit so thresh minus margin cannot wrap
    low_bound = thresh - `RUNNER_HYST;
    if (sample > thresh) begin
      return 1'b1;
    end else if (sample < low_bound) begin
      return 1'b0;
    end
    // inside the band, keep the level
    return cur;
  endfunction

  // thresholds are compared as signed values
  logic signed [`RUNNER_SAMPLE_W-1:0] jump_thresh_s;
  logic signed [`RUNNER_SAMPLE_W-1:0] duck_thresh_s;

  assign jump_thresh_s = $signed(jump_thresh);
  assign duck_thresh_s = $signed(duck_thresh);

  // requests move only on a valid sample
  always_ff @(posedge clk_33m or negedge rst_n) begin
    if (!rst_n) begin
      sensor_jump <= 1'b0;
      sensor_duck <= 1'b0;
    end else if (sample_valid) begin
      // acceleration drives jump
      sensor_jump <= next_req(sensor_jump, acceleration, jump_thresh_s);
      // direction drives duck
      sensor_duck <= next_req(sensor_duck, direction, duck_thresh_s);
    end
  end

endmodule

`default_nettype wire

/* motion_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module motion_merge
  import runner_pkg::*;
(
  input  logic                       clk_33m,
  input  logic                       rst_n,
  // sensor path
  input  logic                       sensor_jump,
  input  logic                       sensor_duck,
  // button path
  input  logic                       btn_jump,
  input  logic                       btn_duck,
  // from the register block
  input  logic                       sensor_en,
  input  logic                       count_clear,
  // to the game core
  output motion_t                    motion,
  output logic                       jumping,
  output logic                       ducking,
  output logic [`RUNNER_COUNT_W-1:0] jump_count
);

  logic want_jump;
  logic want_duck;
  // counter already at its maximum
  logic count_full;

  // sensor only counts when enabled, buttons always do
  assign want_jump = (sensor_jump & sensor_en) | btn_jump;
  // jump wins, duck suppressed
  assign want_duck = ((sensor_duck & sensor_en) | btn_duck) & ~want_jump;

  assign count_full = &jump_count;

  always_ff @(posedge clk_33m or negedge rst_n) begin
    if (!rst_n) begin
      motion     <= MOTION_IDLE;
      jumping    <= 1'b0;
      ducking    <= 1'b0;
      jump_count <= '0;
    end else begin
      jumping <= want_jump;
      ducking <= want_duck;
      if (want_jump) begin
        motion <= MOTION_JUMP;
      end else if (want_duck) begin
        motion <= MOTION_DUCK;
      end else begin
        motion <= MOTION_IDLE;
      end
      // clear beats the increment
      if (count_clear) begin
        jump_count <= '0;
      end else if (want_jump && !jumping && !count_full) begin
        // jumping is about to rise
        jump_count <= jump_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* runner_config.svh */
`ifndef RUNNER_CONFIG_SVH
`define RUNNER_CONFIG_SVH

// sensor sample width, two's complement
`define RUNNER_SAMPLE_W 16

// band below a threshold where a request keeps its level
`define RUNNER_HYST 64

// thresholds loaded at reset
`define RUNNER_JUMP_THRESH_RST 1000
`define RUNNER_DUCK_THRESH_RST 1000

// stable cycles before a button output moves
`define RUNNER_DEBOUNCE_CYCLES 8

// jump counter width, saturating
`define RUNNER_COUNT_W 16

`endif

/* runner_input.f */
+incdir+.
runner_pkg.sv
motion_detector.sv
button_debounce.sv
motion_merge.sv
runner_regs.sv
runner_input_top.sv
runner_input_tb.sv

/* runner_input_stimulus.txt */
# cmd and hex fields: W addr data err, R addr data err, S accel dir,
# B clock_btn duck_btn_n cycles, M motion (0 idle, 1 jump, 2 duck)
R 00 00000001 0
R 04 000003E8 0
R 08 000003E8 0
R 0C 00000000 0
R 10 00000000 0
W 04 000001F4 0
R 04 000001F4 0
W 08 00000190 0
R 08 00000190 0
R 14 00000000 1
W 0C 00000003 1
S 0258 0000
M 1
S 01C2 0000
M 1
S 0190 0000
M 0
S 0000 01F4
M 2
W 00 00000000 0
S 0258 01F4
M 0
S 0000 0000
W 00 00000001 0
B 1 1 3
B 0 1 10
M 0
B 1 1 14
M 1
B 0 0 14
M 2
W 10 00000000 0
S 0258 0000
M 1
S 0000 0000
M 2
B 0 1 14
B 1 1 14
B 0 1 14
B 1 1 14
B 0 1 14
R 10 00000003 0
W 10 00000000 0
R 10 00000000 0

/* runner_input_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module runner_input_tb
  import runner_pkg::*;
();

  // cycles any single wait may take
  localparam int TIMEOUT = 100;

  logic                               clk_33m;
  logic                               rst_n;
  // apb master side
  logic [7:0]                         paddr;
  logic                               psel, penable, pwrite;
  logic [31:0]                        pwdata, prdata;
  logic                               pready, pslverr;
  // sensor and buttons
  logic signed [`RUNNER_SAMPLE_W-1:0] acceleration, direction;
  logic                               sample_valid, clock_btn, duck_btn_n;
  // player motion
  logic                               jumping, ducking;
  motion_t                            motion;
  // motion changes so far, and the count at the last motion check
  int                                 motion_changes;
  int                                 changes_seen;
  // stimulus file fields
  int                                 fd, n;
  string                              op, rest;
  logic [31:0]                        field_a, field_b, field_c, rd_data;
  logic                               rd_err;

  runner_input_top dut_i (.*);

  initial begin
    clk_33m = 1'b0;
    forever #50 clk_33m = ~clk_33m;
  end

  // counts every change of the player motion
  always @(motion) begin
    motion_changes++;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // a command line must carry all of its fields
  task automatic require_fields(input int got, input int want);
    if (got != want) begin
      stop_with_error($sformatf("stimulus command %s has %0d fields instead of %0d",
                                op, got, want));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) stop_with_error($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_with_error($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  // jumping and ducking must agree with the motion
  task automatic check_motion(input motion_t exp);
    if (motion !== exp) stop_with_error($sformatf("ERR motion got %h expected %h", motion, exp));
    check_bit("jumping", jumping, exp == MOTION_JUMP);
    check_bit("ducking", ducking, exp == MOTION_DUCK);
  endtask

  // setup, then access until pready, sampled on the falling edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                          output logic [31:0] rdat, output logic err);
    int waited;
    waited = 0;
    @(posedge clk_33m);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk_33m);
    penable <= 1'b1;
    @(negedge clk_33m);
    while (!pready) begin
      if (waited == TIMEOUT) stop_with_error("apb transfer timed out waiting for pready");
      waited++;
      @(negedge clk_33m);
    end
    // exactly one wait state before pready
    if (waited != 1) begin
      stop_with_error($sformatf("pready came after %0d wait states instead of one", waited));
    end
    rdat = prdata;
    err  = pslverr;
    @(posedge clk_33m);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // one valid pulse, then the two cycles to motion
  task automatic send_sample(input logic [15:0] acc, input logic [15:0] dir);
    @(posedge clk_33m);
    acceleration <= acc;
    direction    <= dir;
    sample_valid <= 1'b1;
    @(posedge clk_33m);
    sample_valid <= 1'b0;
    @(posedge clk_33m);
  endtask

  task automatic hold_buttons(input logic jump_lvl, input logic duck_lvl_n, input int cycles);
    @(posedge clk_33m);
    clock_btn  <= jump_lvl;
    duck_btn_n <= duck_lvl_n;
    repeat (cycles) @(posedge clk_33m);
  endtask

  task automatic wait_motion(input motion_t exp);
    int waited;
    waited = 0;
    @(negedge clk_33m);
    while (motion !== exp && waited < TIMEOUT) begin
      waited++;
      @(negedge clk_33m);
    end
    if (motion !== exp) $display("motion did not settle within %0d cycles", TIMEOUT);
    check_motion(exp);
    // a short glitch away from the expected motion shows up as a second change
    if (motion_changes - changes_seen > 1) begin
      stop_with_error($sformatf("motion changed %0d times since the last motion check",
                                motion_changes - changes_seen));
    end
    changes_seen = motion_changes;
  endtask

  initial begin
    rst_n        = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    acceleration = '0;
    direction    = '0;
    sample_valid = 1'b0;
    clock_btn    = 1'b0;
    duck_btn_n   = 1'b1;
    repeat (2) @(posedge clk_33m);
    rst_n <= 1'b1;
    changes_seen = motion_changes;
    fd = $fopen("runner_input_stimulus.txt", "r");
    if (fd == 0) stop_with_error("could not open the stimulus file runner_input_stimulus.txt");
    // one command token per line, fields follow in hex
    while ($fscanf(fd, "%s", op) == 1) begin
      case (op)
        "#": n = $fgets(rest, fd);
        "W": begin
          n = $fscanf(fd, "%h %h %h", field_a, field_b, field_c);
          require_fields(n, 3);
          apb_xfer(1'b1, field_a[7:0], field_b, rd_data, rd_err);
          check_bit("pslverr", rd_err, field_c[0]);
        end
        "R": begin
          n = $fscanf(fd, "%h %h %h", field_a, field_b, field_c);
          require_fields(n, 3);
          apb_xfer(1'b0, field_a[7:0], '0, rd_data, rd_err);
          check_bit("pslverr", rd_err, field_c[0]);
          // read data only matters on a good access
          if (!field_c[0]) check_word("prdata", rd_data, field_b);
        end
        "S": begin
          n = $fscanf(fd, "%h %h", field_a, field_b);
          require_fields(n, 2);
          send_sample(field_a[15:0], field_b[15:0]);
        end
        "B": begin
          n = $fscanf(fd, "%h %h %h", field_a, field_b, field_c);
          require_fields(n, 3);
          hold_buttons(field_a[0], field_b[0], field_c);
        end
        "M": begin
          n = $fscanf(fd, "%h", field_a);
          require_fields(n, 1);
          wait_motion(motion_t'(field_a[1:0]));
        end
        default: stop_with_error($sformatf("unknown command %s in the stimulus file", op));
      endcase
    end
    $fclose(fd);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* runner_input_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module runner_input_top
  import runner_pkg::*;
(
  input  logic                               clk_33m,
  input  logic                               rst_n,
  // apb
  input  logic [7:0]                         paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  // wireless sensor, already decoded
  input  logic signed [`RUNNER_SAMPLE_W-1:0] acceleration,
  input  logic signed [`RUNNER_SAMPLE_W-1:0] direction,
  input  logic                               sample_valid,
  // board buttons
  input  logic                               clock_btn,
  input  logic                               duck_btn_n,
  // player motion
  output logic                               jumping,
  output logic                               ducking,
  output motion_t                            motion
);

  // register block controls
  logic [`RUNNER_SAMPLE_W-1:0] jump_thresh;
  logic [`RUNNER_SAMPLE_W-1:0] duck_thresh;
  logic                        sensor_en;
  logic                        count_clear;
  // requests from both paths
  logic                        sensor_jump;
  logic                        sensor_duck;
  logic                        btn_jump;
  logic                        btn_duck;
  logic [`RUNNER_COUNT_W-1:0]  jump_count;

  // sensor path, one cycle
  motion_detector motion_detector_inst (
    .clk_33m,
    .rst_n,
    .acceleration,
    .direction,
    .sample_valid,
    .jump_thresh,
    .duck_thresh,
    .sensor_jump,
    .sensor_duck
  );

  // button path, debounce plus synchronizer
  button_debounce button_debounce_inst (
    .clk_33m,
    .rst_n,
    .clock_btn,
    .duck_btn_n,
    .btn_jump,
    .btn_duck
  );

  // priority and jump counting, one cycle
  motion_merge motion_merge_inst (
    .clk_33m,
    .rst_n,
    .sensor_jump,
    .sensor_duck,
    .btn_jump,
    .btn_duck,
    .sensor_en,
    .count_clear,
    .motion,
    .jumping,
    .ducking,
    .jump_count
  );

  runner_regs runner_regs_inst (
    .clk_33m,
    .rst_n,
    .paddr,
    .psel,
    .penable,
    .pwrite,
    .pwdata,
    .prdata,
    .pready,
    .pslverr,
    .motion,
    .jump_count,
    .jump_thresh,
    .duck_thresh,
    .sensor_en,
    .count_clear
  );

endmodule

`default_nettype wire

/* runner_pkg.sv */
`default_nettype none

package runner_pkg;

  // player motion as seen by the game core
  typedef enum logic [1:0] {
    MOTION_IDLE = 2'd0,
    // jump has priority over duck
    MOTION_JUMP = 2'd1,
    MOTION_DUCK = 2'd2
  } motion_t;

  // apb slave progress through one transfer
  typedef enum logic [1:0] {
    // waiting for a setup cycle
    APB_IDLE        = 2'd0,
    // setup seen, first access cycle is the wait state
    APB_SETUP_SEEN  = 2'd1,
    // pready high this cycle
    APB_ACCESS_DONE = 2'd2
  } apb_phase_t;

  // register byte addresses
  typedef enum logic [7:0] {
    REG_CTRL        = 8'h00,
    REG_JUMP_THRESH = 8'h04,
    REG_DUCK_THRESH = 8'h08,
    // read only
    REG_STATUS      = 8'h0C,
    REG_JUMP_COUNT  = 8'h10
  } reg_addr_t;

endpackage

`default_nettype wire

/* runner_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "runner_config.svh"

module runner_regs
  import runner_pkg::*;
(
  input  logic                        clk_33m,
  input  logic                        rst_n,
  // apb slave
  input  logic [7:0]                  paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  // status in
  input  motion_t                     motion,
  input  logic [`RUNNER_COUNT_W-1:0]  jump_count,
  // control out
  output logic [`RUNNER_SAMPLE_W-1:0] jump_thresh,
  output logic [`RUNNER_SAMPLE_W-1:0] duck_thresh,
  output logic                        sensor_en,
  output logic                        count_clear
);

  apb_phase_t  apb_state;
  reg_addr_t   addr;
  // first access cycle, the wait state
  logic        access_fire;
  logic        addr_hit;
  logic        bad_access;
  logic        wr_ok;
  logic [31:0] rd_word;

  assign addr        = reg_addr_t'(paddr);
  assign access_fire = (apb_state == APB_SETUP_SEEN) && psel && penable;

  // address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    rd_word  = '0;
    case (addr)
      REG_CTRL:        rd_word[0] = sensor_en;
      REG_JUMP_THRESH: rd_word[`RUNNER_SAMPLE_W-1:0] = jump_thresh;
      REG_DUCK_THRESH: rd_word[`RUNNER_SAMPLE_W-1:0] = duck_thresh;
      REG_STATUS:      rd_word[1:0] = motion;
      REG_JUMP_COUNT:  rd_word[`RUNNER_COUNT_W-1:0] = jump_count;
      default:         addr_hit = 1'b0;
    endcase
  end

  // unmapped address, or a write to the read-only status
  assign bad_access = ~addr_hit | (pwrite & (addr == REG_STATUS));
  assign wr_ok      = access_fire & pwrite & ~bad_access;

  // pready only in the second access cycle
  assign pready = (apb_state == APB_ACCESS_DONE);

  always_ff @(posedge clk_33m or negedge rst_n) begin
    if (!rst_n) begin
      apb_state   <= APB_IDLE;
      pslverr     <= 1'b0;
      count_clear <= 1'b0;
      sensor_en   <= 1'b1;
      jump_thresh <= `RUNNER_SAMPLE_W'(`RUNNER_JUMP_THRESH_RST);
      duck_thresh <= `RUNNER_SAMPLE_W'(`RUNNER_DUCK_THRESH_RST);
    end else begin
      // one cycle pulse
      count_clear <= wr_ok & (addr == REG_JUMP_COUNT);
      case (apb_state)
        APB_IDLE: begin
          pslverr <= 1'b0;
          if (psel && !penable) begin
            apb_state <= APB_SETUP_SEEN;
          end
        end
        APB_SETUP_SEEN: begin
          if (access_fire) begin
            apb_state <= APB_ACCESS_DONE;
            // error shows up with pready
            pslverr   <= bad_access;
          end else if (!psel) begin
            // master dropped the transfer
            apb_state <= APB_IDLE;
          end
        end
        default: begin
          // transfer ends here
          apb_state <= APB_IDLE;
          pslverr   <= 1'b0;
        end
      endcase
      if (wr_ok) begin
        case (addr)
          REG_CTRL:        sensor_en <= pwdata[0];
          REG_JUMP_THRESH: jump_thresh <= pwdata[`RUNNER_SAMPLE_W-1:0];
          REG_DUCK_THRESH: duck_thresh <= pwdata[`RUNNER_SAMPLE_W-1:0];
          // jump count write only clears, handled above
          default:         ;
        endcase
      end
    end
  end

  // read data lands together with pready
  always_ff @(posedge clk_33m) begin
    if (access_fire) begin
      prdata <= rd_word;
    end
  end

endmodule

`default_nettype wire
